// ==== design/idle_insertion_pkg.sv ====
package idle_insertion_pkg;

	// Block format, data sits above the control mask
	localparam int TX_DATA_W = 64;
	localparam int TX_CTRL_W = 8;
	localparam int BLOCK_W   = TX_DATA_W + TX_CTRL_W;

	localparam logic [7:0] IDLE_CHAR = 8'h07;  // CGMII idle

	// Full idle block as seen on the input
	localparam logic [TX_DATA_W-1:0] IDLE_DATA = {(TX_DATA_W/8){IDLE_CHAR}};
	localparam logic [TX_CTRL_W-1:0] IDLE_CTRL = '1;

	// Marker period, counted in taken blocks
	localparam int AM_PERIOD = 16383;
	localparam int AM_CNT_W  = 14;

	// Marker window length in enabled cycles
	localparam int AM_LANES  = 20;
	localparam int WIN_CNT_W = 5;

	// Idles removed per period to make room for the markers
	localparam int IDLE_DEL_MAX = 20;
	localparam int DEL_CNT_W    = 5;

	// Elastic buffer
	localparam int FIFO_DEPTH  = 32;
	localparam int FIFO_ADDR_W = 5;

endpackage

// ==== design/fifo_if.sv ====
interface fifo_if;
	import idle_insertion_pkg::*;

	// Write side
	logic               wr_en;
	logic [BLOCK_W-1:0] wr_data;

	// Read side
	logic               rd_en;
	logic [BLOCK_W-1:0] rd_data;  // Registered in the FIFO

	// Status
	logic empty;
	logic full;

	// Controller pushes, pops and watches the flags
	modport ctrl (
		output wr_en,
		output wr_data,
		output rd_en,
		input  rd_data,
		input  empty,
		input  full
	);

	modport fifo (
		input  wr_en,
		input  wr_data,
		input  rd_en,
		output rd_data,
		output empty,
		output full
	);

endinterface

// ==== design/am_block_counter.sv ====
module am_block_counter (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_enable,
	input  logic i_block_taken,
	output logic o_period_done,
	output logic o_am_window
);
	import idle_insertion_pkg::*;

	logic [AM_CNT_W-1:0]  block_cnt;
	logic [WIN_CNT_W-1:0] win_cnt;
	logic                 last_block;  // Period ends on this take

	assign last_block = i_block_taken && (block_cnt == AM_CNT_W'(AM_PERIOD - 1));

	// Modulo counter over taken blocks, deleted idles included
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			block_cnt     <= '0;
			o_period_done <= 1'b0;
		end else if (i_enable) begin
			o_period_done <= last_block;
			if (last_block)
				block_cnt <= '0;
			else if (i_block_taken)
				block_cnt <= block_cnt + 1'b1;
		end
	end

	// Window opens together with period_done and lasts AM_LANES enabled cycles
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			o_am_window <= 1'b0;
			win_cnt     <= '0;
		end else if (i_enable) begin
			if (last_block) begin
				o_am_window <= 1'b1;
				win_cnt     <= '0;
			end else if (o_am_window) begin
				if (win_cnt == WIN_CNT_W'(AM_LANES - 1))
					o_am_window <= 1'b0;  // Last window cycle
				else
					win_cnt <= win_cnt + 1'b1;
			end
		end
	end

endmodule

// ==== design/idle_deletion_counter.sv ====
module idle_deletion_counter (
	input  logic i_clock,
	input  logic i_rst_n,
	input  logic i_enable,
	input  logic i_idle_del,
	input  logic i_period_done,
	output logic o_quota_done
);
	import idle_insertion_pkg::*;

	logic [DEL_CNT_W-1:0] del_cnt;
	logic                 at_max;

	assign at_max = (del_cnt == DEL_CNT_W'(IDLE_DEL_MAX));

	// Deletions in the current period
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			del_cnt <= '0;
		end else if (i_enable) begin
			if (i_period_done)
				// First block of the new period may already be a deleted idle
				del_cnt <= i_idle_del ? DEL_CNT_W'(1) : '0;
			else if (i_idle_del && !at_max)
				del_cnt <= del_cnt + 1'b1;  // Saturates at the quota
		end
	end

	// The old period's count is stale once period_done is up
	assign o_quota_done = at_max && !i_period_done;

endmodule

// ==== design/sync_fifo.sv ====
module sync_fifo (
	input  logic   i_clock,
	input  logic   i_rst_n,
	input  logic   i_enable,
	fifo_if.fifo   fifo
);
	import idle_insertion_pkg::*;

	logic [BLOCK_W-1:0] mem [FIFO_DEPTH];

	// Extra MSB tells a full buffer from an empty one
	logic [FIFO_ADDR_W:0] wr_ptr;
	logic [FIFO_ADDR_W:0] rd_ptr;

	logic do_write;
	logic do_read;

	assign fifo.empty = (wr_ptr == rd_ptr);
	assign fifo.full  = (wr_ptr[FIFO_ADDR_W] != rd_ptr[FIFO_ADDR_W]) &&
		(wr_ptr[FIFO_ADDR_W-1:0] == rd_ptr[FIFO_ADDR_W-1:0]);

	// Write into a full buffer is dropped
	assign do_write = i_enable && fifo.wr_en && !fifo.full;
	assign do_read  = i_enable && fifo.rd_en && !fifo.empty;

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
		end else if (do_write) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			rd_ptr <= '0;
		end else if (do_read) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge i_clock) begin
		if (do_write)
			mem[wr_ptr[FIFO_ADDR_W-1:0]] <= fifo.wr_data;
	end

	// Read port, holds its value between reads
	always_ff @(posedge i_clock) begin
		if (do_read)
			fifo.rd_data <= mem[rd_ptr[FIFO_ADDR_W-1:0]];
	end

endmodule

// ==== design/idle_insertion_ctrl.sv ====
module idle_insertion_ctrl (
	input  logic                                 i_clock,
	input  logic                                 i_rst_n,
	input  logic                                 i_enable,
	input  logic                                 i_valid,
	input  logic [idle_insertion_pkg::TX_DATA_W-1:0] i_tx_data,
	input  logic [idle_insertion_pkg::TX_CTRL_W-1:0] i_tx_ctrl,
	input  logic                                 i_am_window,
	input  logic                                 i_quota_done,
	output logic                                 o_block_taken,
	output logic                                 o_idle_del,
	fifo_if.ctrl                                 fifo,
	output logic [idle_insertion_pkg::TX_DATA_W-1:0] o_tx_data,
	output logic [idle_insertion_pkg::TX_CTRL_W-1:0] o_tx_ctrl,
	output logic                                 o_valid,
	output logic                                 o_am_flag,
	output logic                                 o_overflow
);
	import idle_insertion_pkg::*;

	logic is_idle;
	logic valid_q;

	// Idle block has every control bit set and only idle bytes
	assign is_idle = (i_tx_ctrl == IDLE_CTRL) && (i_tx_data == IDLE_DATA);

	assign o_block_taken = i_valid && i_enable;
	assign o_idle_del    = o_block_taken && is_idle && !i_quota_done;

	// Everything not deleted goes into the FIFO
	assign fifo.wr_en   = o_block_taken && !o_idle_del;
	assign fifo.wr_data = {i_tx_data, i_tx_ctrl};

	// Output stalls while the marker inserter owns the lane
	assign fifo.rd_en = i_enable && !i_am_window && !fifo.empty;

	// Valid and flag follow the read by one enabled cycle,
	// so a block read just before the window never meets the flag
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			valid_q   <= 1'b0;
			o_am_flag <= 1'b0;
		end else if (i_enable) begin
			valid_q   <= fifo.rd_en;
			o_am_flag <= i_am_window;
		end
	end

	// Held block shows up again on the next enabled cycle
	assign o_valid = valid_q && i_enable;

	assign o_tx_data = fifo.rd_data[BLOCK_W-1 -: TX_DATA_W];
	assign o_tx_ctrl = fifo.rd_data[TX_CTRL_W-1:0];

	// Sticky until reset
	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			o_overflow <= 1'b0;
		else if (fifo.wr_en && fifo.full)
			o_overflow <= 1'b1;  // Block lost
	end

endmodule

// ==== design/idle_insertion_top.sv ====
module idle_insertion_top (
	input  logic                                     i_clock,
	input  logic                                     i_rst_n,
	input  logic                                     i_enable,
	input  logic                                     i_valid,
	input  logic [idle_insertion_pkg::TX_DATA_W-1:0] i_tx_data,
	input  logic [idle_insertion_pkg::TX_CTRL_W-1:0] i_tx_ctrl,
	output logic [idle_insertion_pkg::TX_DATA_W-1:0] o_tx_data,
	output logic [idle_insertion_pkg::TX_CTRL_W-1:0] o_tx_ctrl,
	output logic                                     o_valid,
	output logic                                     o_am_flag,
	output logic                                     o_overflow
);

	logic block_taken;
	logic idle_del;
	logic period_done;
	logic am_window;   // Read stall, flag comes out of the controller
	logic quota_done;

	fifo_if u_fifo_if ();

	idle_insertion_ctrl u_idle_insertion_ctrl (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_enable      (i_enable),
		.i_valid       (i_valid),
		.i_tx_data     (i_tx_data),
		.i_tx_ctrl     (i_tx_ctrl),
		.i_am_window   (am_window),
		.i_quota_done  (quota_done),
		.o_block_taken (block_taken),
		.o_idle_del    (idle_del),
		.fifo          (u_fifo_if),
		.o_tx_data     (o_tx_data),
		.o_tx_ctrl     (o_tx_ctrl),
		.o_valid       (o_valid),
		.o_am_flag     (o_am_flag),
		.o_overflow    (o_overflow)
	);

	am_block_counter u_am_block_counter (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_enable      (i_enable),
		.i_block_taken (block_taken),
		.o_period_done (period_done),
		.o_am_window   (am_window)
	);

	idle_deletion_counter u_idle_deletion_counter (
		.i_clock       (i_clock),
		.i_rst_n       (i_rst_n),
		.i_enable      (i_enable),
		.i_idle_del    (idle_del),
		.i_period_done (period_done),
		.o_quota_done  (quota_done)
	);

	sync_fifo u_sync_fifo (
		.i_clock  (i_clock),
		.i_rst_n  (i_rst_n),
		.i_enable (i_enable),
		.fifo     (u_fifo_if)
	);

endmodule

// ==== testbench/idle_insertion_chk.sv ====
module idle_insertion_chk (
	input logic i_clock,
	input logic i_rst_n,
	input logic i_enable,
	input logic o_valid,
	input logic o_am_flag,
	input logic o_overflow
);
	import idle_insertion_pkg::*;

	logic [5:0] run_len;  // Enabled cycles of the current flag run

	always_ff @(posedge i_clock) begin
		if (!i_rst_n)
			run_len <= '0;
		else if (i_enable) begin
			if (o_am_flag)
				run_len <= run_len + 1'b1;
			else
				run_len <= '0;
		end
	end

	// Output block and marker slot share the lane, never both
	assert property (@(posedge i_clock) disable iff (!i_rst_n) !(o_valid && o_am_flag))
		else $error("o_valid and o_am_flag high in the same cycle");

	// Flag run ends after exactly AM_LANES enabled cycles
	assert property (@(posedge i_clock) disable iff (!i_rst_n)
		(i_enable && !o_am_flag && run_len != 0) |-> (run_len == 6'(AM_LANES)))
		else $error("marker flag run of wrong length");

	assert property (@(posedge i_clock) disable iff (!i_rst_n) run_len <= 6'(AM_LANES))
		else $error("marker flag run too long");

	assert property (@(posedge i_clock) !i_rst_n |=> (!o_valid && !o_am_flag && !o_overflow))
		else $error("outputs active during reset");

endmodule

bind idle_insertion_top idle_insertion_chk u_idle_insertion_chk (
	.i_clock    (i_clock),
	.i_rst_n    (i_rst_n),
	.i_enable   (i_enable),
	.o_valid    (o_valid),
	.o_am_flag  (o_am_flag),
	.o_overflow (o_overflow)
);

// ==== testbench/tb_idle_insertion.sv ====
module tb_idle_insertion;
	import idle_insertion_pkg::*;

	localparam int N_LONG  = AM_PERIOD + 500;
	localparam int N_WIN   = 24000;
	localparam int N_FRZ   = 2 * AM_PERIOD;  // Long enough to cross a marker window
	localparam int N_OVF   = 2 * AM_PERIOD + 100;
	localparam int DRAIN   = 500;
	localparam int LIMIT   = (2 * N_LONG + N_WIN + N_FRZ + N_OVF + 5 * DRAIN + 50) * 11 / 10;

	logic                 clock = 1'b0;
	logic                 rst_n;
	logic                 enable;
	logic                 valid;
	logic [TX_DATA_W-1:0] tx_data;
	logic [TX_CTRL_W-1:0] tx_ctrl;
	logic [TX_DATA_W-1:0] out_data;
	logic [TX_CTRL_W-1:0] out_ctrl;
	logic                 out_valid;
	logic                 am_flag;
	logic                 overflow;

	integer         seed = 32'he8655255;
	int             errors = 0;
	int             failed_tests = 0;
	int             cycles = 0;
	string          cur_test = "reset";
	bit             compare_en = 1'b1;

	// Reference model state
	logic [BLOCK_W-1:0] model_q[$];
	int             period_cnt;
	int             del_cnt;
	int             periods_done;
	int             kept_idles;

	// Observed at the output
	int             windows_seen;
	int             flag_run;
	int             out_idles;
	logic           flag_prev;
	logic           en_prev;   // Enable of the cycle that last clocked the flag

	idle_insertion_top u_idle_insertion_top (
		.i_clock    (clock),
		.i_rst_n    (rst_n),
		.i_enable   (enable),
		.i_valid    (valid),
		.i_tx_data  (tx_data),
		.i_tx_ctrl  (tx_ctrl),
		.o_tx_data  (out_data),
		.o_tx_ctrl  (out_ctrl),
		.o_valid    (out_valid),
		.o_am_flag  (am_flag),
		.o_overflow (overflow)
	);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles > LIMIT) begin
			$display("Timeout after %0d cycles in test %s", cycles, cur_test);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic bit block_is_idle(logic [TX_DATA_W-1:0] d, logic [TX_CTRL_W-1:0] c);
		return (c == 8'hff) && (d == {8{8'h07}});
	endfunction

	function automatic int pick(int pct);
		integer r;
		r = $random(seed);
		return ((r & 32'h7fffffff) % 100) < pct;
	endfunction

	// Outputs sampled at the posedge before the flops update
	always @(posedge clock) begin
		if (!rst_n) begin
			flag_prev <= 1'b0;
			en_prev   <= 1'b0;
			flag_run  <= 0;
		end else begin
			if (out_valid && compare_en) begin
				if (model_q.size() == 0) begin
					$display("Output block in %s while the model queue is empty", cur_test);
					errors++;
				end else if (model_q[0] != {out_data, out_ctrl}) begin
					$display("Mismatch in %s: expected %h, actual %h",
						cur_test, model_q[0], {out_data, out_ctrl});
					errors++;
					void'(model_q.pop_front());
				end else begin
					void'(model_q.pop_front());
				end
			end
			if (out_valid && block_is_idle(out_data, out_ctrl))
				out_idles <= out_idles + 1;
			if (!enable && out_valid) begin
				$display("o_valid high with enable low in %s", cur_test);
				errors++;
			end
			if (!en_prev && am_flag != flag_prev) begin
				$display("o_am_flag changed with enable low in %s", cur_test);
				errors++;
			end
			if (out_valid && am_flag) begin
				$display("o_valid high inside the marker window in %s", cur_test);
				errors++;
			end
			if (am_flag && !flag_prev)
				windows_seen <= windows_seen + 1;
			if (!am_flag && flag_prev) begin
				if (flag_run != AM_LANES) begin
					$display("Mismatch in %s: expected %0d, actual %0d",
						cur_test, AM_LANES, flag_run);
					errors++;
				end
				flag_run <= 0;
			end else if (am_flag && enable) begin
				flag_run <= flag_run + 1;
			end
			flag_prev <= am_flag;
			en_prev   <= enable;
		end
	end

	task automatic apply_reset();
		@(negedge clock);
		rst_n   = 1'b0;
		enable  = 1'b0;
		valid   = 1'b0;
		model_q.delete();
		period_cnt   = 0;
		del_cnt      = 0;
		periods_done = 0;
		windows_seen = 0;
		repeat (5) @(negedge clock);
		rst_n = 1'b1;
	endtask

	// One block per cycle with the take and delete rules applied to the model
	task automatic run_stim(int n, int valid_pct, int idle_pct, int enable_pct);
		for (int i = 0; i < n; i++) begin
			@(negedge clock);
			enable = pick(enable_pct);
			valid  = pick(valid_pct);
			if (pick(idle_pct)) begin
				tx_data = {8{IDLE_CHAR}};
				tx_ctrl = 8'hff;
			end else begin
				tx_data = {$random(seed), $random(seed)};
				tx_ctrl = 8'($random(seed));
			end
			if (valid && enable) begin
				if (block_is_idle(tx_data, tx_ctrl) && del_cnt < IDLE_DEL_MAX) begin
					del_cnt++;  // Dropped to make room
				end else begin
					model_q.push_back({tx_data, tx_ctrl});
					if (block_is_idle(tx_data, tx_ctrl))
						kept_idles++;
				end
				period_cnt++;
				if (period_cnt == AM_PERIOD) begin
					period_cnt = 0;
					del_cnt    = 0;
					periods_done++;
				end
			end
		end
	endtask

	task automatic drain();
		int n;
		n = 0;
		@(negedge clock);
		valid  = 1'b0;
		enable = 1'b1;
		while (model_q.size() != 0 || am_flag || out_valid) begin
			@(negedge clock);
			n++;
			if (n > DRAIN) begin
				$display("Drain did not finish in %s, %0d blocks left", cur_test, model_q.size());
				errors++;
				break;
			end
		end
		repeat (5) @(negedge clock);
	endtask

	task automatic start_test(string name);
		cur_test   = name;
		kept_idles = 0;
		out_idles  = 0;
	endtask

	task automatic end_test(int err_before);
		if (errors == err_before) begin
			$display("Test %s: PASS", cur_test);
		end else begin
			$display("Test %s: FAIL, %0d errors", cur_test, errors - err_before);
			failed_tests++;
		end
	endtask

	initial begin
		int e;
		int p0;
		rst_n   = 1'b0;
		enable  = 1'b0;
		valid   = 1'b0;
		tx_data = '0;
		tx_ctrl = '0;
		apply_reset();

		e = errors;
		start_test("data_integrity");
		run_stim(N_LONG, 100, 30, 100);
		drain();
		end_test(e);

		e = errors;
		start_test("deletion_quota");
		run_stim(N_LONG, 100, 60, 100);
		drain();
		if (out_idles != kept_idles) begin
			$display("Mismatch in %s: expected %0d, actual %0d", cur_test, kept_idles, out_idles);
			errors++;
		end
		end_test(e);

		e = errors;
		start_test("marker_window");
		p0 = periods_done;
		run_stim(N_WIN, 70, 10, 100);
		drain();
		if (periods_done == p0) begin
			$display("No marker period completed in %s", cur_test);
			errors++;
		end
		if (windows_seen != periods_done) begin
			$display("Mismatch in %s: expected %0d, actual %0d", cur_test, periods_done, windows_seen);
			errors++;
		end
		end_test(e);

		e = errors;
		start_test("enable_freeze");
		p0 = periods_done;
		run_stim(N_FRZ, 80, 30, 75);
		drain();
		if (periods_done == p0) begin
			$display("No marker period completed in %s", cur_test);
			errors++;
		end
		end_test(e);

		// Model cannot follow dropped writes in the overflow run
		e = errors;
		start_test("overflow");
		compare_en = 1'b0;
		apply_reset();
		run_stim(AM_PERIOD + AM_LANES + 10, 100, 0, 100);
		if (overflow) begin
			$display("o_overflow set after the first window");
			errors++;
		end
		run_stim(N_OVF - AM_PERIOD - AM_LANES - 10, 100, 0, 100);
		if (!overflow) begin
			$display("o_overflow not set after the second window");
			errors++;
		end
		apply_reset();
		@(negedge clock);
		if (overflow) begin
			$display("o_overflow still set after reset");
			errors++;
		end
		end_test(e);

		$display("Tests run: 5, failed: %0d, errors: %0d", failed_tests, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== list.f ====
design/idle_insertion_pkg.sv
design/fifo_if.sv
design/am_block_counter.sv
design/idle_deletion_counter.sv
design/sync_fifo.sv
design/idle_insertion_ctrl.sv
design/idle_insertion_top.sv
testbench/idle_insertion_chk.sv
testbench/tb_idle_insertion.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_idle_insertion -f list.f -o sim_tb \
	&& ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Done: no errors" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
